// File: ghash_pkg.sv
package ghash_pkg;

   // Block width fixed by GCM.
   localparam int NB_DATA = 128;

   // Bits of X folded per multiplier cycle.
   // Must divide NB_DATA.
   localparam int NB_DIGIT_DEFAULT = 4;

   // Width of the AAD and text block counters.
   localparam int NB_COUNT = 32;

   // Width of each half of the length block.
   localparam int NB_LEN_FIELD = 64;

   // A full block is 128 bits, so bit count is block count shifted by 7.
   localparam int NB_BLOCK_SHIFT = 7;

   // Reduction word, x^128 + x^7 + x^2 + x + 1 in GCM bit order.
   localparam logic [NB_DATA-1:0] GCM_R = {8'he1, 120'd0};

   // Length block fields.
   typedef struct packed
   {
      logic [NB_LEN_FIELD-1:0] aad_bits;
      logic [NB_LEN_FIELD-1:0] text_bits;
   } ghash_len_t;

   // One block seen as raw data or as the length block.
   typedef union packed
   {
      logic [NB_DATA-1:0] raw;
      ghash_len_t         len;
   } ghash_block_u;

endpackage

// File: ghash_ctrl_pkg.sv
package ghash_ctrl_pkg;

   // Control FSM states.
   // S_IDLE waits for start, S_READY accepts blocks or finish.
   // S_MULT runs one block through the multiplier.
   // S_LEN sets up the length block, S_LEN_MULT hashes it.
   // S_DONE presents the result for one cycle.
   typedef enum logic [2:0]
   {
      S_IDLE     = 3'd0,
      S_READY    = 3'd1,
      S_MULT     = 3'd2,
      S_LEN      = 3'd3,
      S_LEN_MULT = 3'd4,
      S_DONE     = 3'd5
   } ghash_state_e;

endpackage

// File: mult_if.sv
interface mult_if;

   import ghash_pkg::*;

   // Sequencing.
   logic               load;
   logic               step;
   logic               last;

   // Operands and result.
   logic [NB_DATA-1:0] operand_x;
   logic [NB_DATA-1:0] key_h;
   logic [NB_DATA-1:0] product;

   modport ctrl
   (
      output load,
      input  last
   );

   modport timer
   (
      input  load,
      output step,
      output last
   );

   modport datapath
   (
      input  load,
      input  step,
      input  operand_x,
      input  key_h,
      output product
   );

   modport source
   (
      output operand_x,
      output key_h,
      input  product
   );

endinterface

// File: gf_multiplier_gcm_spec.sv
module gf_multiplier_gcm_spec
#(
   parameter int NB_DIGIT = ghash_pkg::NB_DIGIT_DEFAULT
)
(
   input  logic    i_clock,
   input  logic    i_reset,
   mult_if.datapath mult
);

   import ghash_pkg::*;

   // Remaining X bits, most significant first.
   logic [NB_DATA-1:0] x_q;
   // H shifted once per consumed bit.
   logic [NB_DATA-1:0] v_q;
   // Partial product.
   logic [NB_DATA-1:0] z_q;

   logic [NB_DATA-1:0] z_next;
   logic [NB_DATA-1:0] v_next;

   // One digit of the GCM right-shift multiply, unrolled.
   always_comb
   begin
      z_next = z_q;
      v_next = v_q;
      for (int i = 0; i < NB_DIGIT; i++)
      begin
         if (x_q[NB_DATA-1-i])
         begin
            z_next = z_next ^ v_next;
         end
         // Bit 0 is the highest power in GCM order.
         if (v_next[0])
         begin
            v_next = (v_next >> 1) ^ GCM_R;
         end
         else
         begin
            v_next = v_next >> 1;
         end
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (mult.load)
      begin
         x_q <= mult.operand_x;
         v_q <= mult.key_h;
      end
      else if (mult.step)
      begin
         x_q <= x_q << NB_DIGIT;
         v_q <= v_next;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         z_q <= '0;
      end
      else if (mult.load)
      begin
         z_q <= '0;
      end
      else if (mult.step)
      begin
         z_q <= z_next;
      end
   end

   // Valid from the cycle after last until the next load.
   assign mult.product = z_q;

endmodule

// File: ghash_step_counter.sv
module ghash_step_counter
#(
   parameter int NB_DIGIT = ghash_pkg::NB_DIGIT_DEFAULT
)
(
   input  logic  i_clock,
   input  logic  i_reset,
   mult_if.timer mult
);

   import ghash_pkg::*;

   // Digits per block.
   localparam int N_STEPS       = NB_DATA / NB_DIGIT;
   localparam int NB_STEP_COUNT = $clog2(N_STEPS + 1);

   logic [NB_STEP_COUNT-1:0] count_q;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         count_q <= '0;
      end
      else if (mult.load)
      begin
         count_q <= NB_STEP_COUNT'(N_STEPS);
      end
      else if (count_q != '0)
      begin
         count_q <= count_q - 1'b1;
      end
   end

   // Steps run while digits remain.
   assign mult.step = (count_q != '0);
   assign mult.last = (count_q == NB_STEP_COUNT'(1));

endmodule

// File: ghash_accumulator.sv
module ghash_accumulator
(
   input  logic                          i_clock,
   input  logic                          i_reset,
   mult_if.source                        mult,
   input  logic                          i_clear,
   input  logic                          i_write,
   input  logic                          i_count_block,
   input  logic                          i_is_aad,
   input  logic                          i_use_len,
   input  logic [ghash_pkg::NB_DATA-1:0] i_h_key,
   input  logic [ghash_pkg::NB_DATA-1:0] i_data_x,
   output logic [ghash_pkg::NB_DATA-1:0] o_data_y
);

   import ghash_pkg::*;

   // Zero bits above a shifted count in one length field.
   localparam int NB_PAD = NB_LEN_FIELD - NB_COUNT - NB_BLOCK_SHIFT;

   logic [NB_DATA-1:0]  y_q;
   logic [NB_DATA-1:0]  h_q;
   logic [NB_DATA-1:0]  x_q;
   logic [NB_COUNT-1:0] aad_count_q;
   logic [NB_COUNT-1:0] text_count_q;
   ghash_block_u        len_block;

   // Running hash and subkey.
   always_ff @(posedge i_clock)
   begin
      if (i_clear)
      begin
         y_q <= '0;
         h_q <= i_h_key;
      end
      else if (i_write)
      begin
         y_q <= mult.product;
      end
   end

   // Block is held for the whole multiply.
   always_ff @(posedge i_clock)
   begin
      if (i_count_block)
      begin
         x_q <= i_data_x;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset || i_clear)
      begin
         aad_count_q  <= '0;
         text_count_q <= '0;
      end
      else if (i_count_block)
      begin
         if (i_is_aad)
         begin
            aad_count_q <= aad_count_q + 1'b1;
         end
         else
         begin
            text_count_q <= text_count_q + 1'b1;
         end
      end
   end

   // Bit counts, AAD in the upper half.
   always_comb
   begin
      len_block.len.aad_bits  = {{NB_PAD{1'b0}}, aad_count_q, {NB_BLOCK_SHIFT{1'b0}}};
      len_block.len.text_bits = {{NB_PAD{1'b0}}, text_count_q, {NB_BLOCK_SHIFT{1'b0}}};
   end

   assign mult.operand_x = y_q ^ (i_use_len ? len_block.raw : x_q);
   assign mult.key_h     = h_q;
   assign o_data_y       = y_q;

endmodule

// File: ghash_fsm.sv
module ghash_fsm
(
   input  logic i_clock,
   input  logic i_reset,
   input  logic i_start,
   input  logic i_valid,
   input  logic i_finish,
   mult_if.ctrl mult,
   output logic o_clear,
   output logic o_write,
   output logic o_count_block,
   output logic o_use_len,
   output logic o_ready,
   output logic o_valid
);

   import ghash_ctrl_pkg::*;

   ghash_state_e state_q;
   ghash_state_e state_next;
   logic         load_q;
   logic         write_q;
   logic         accept_start;
   logic         accept_block;
   logic         enter_mult;

   // Start is taken whenever no multiply is in flight.
   assign accept_start = i_start &&
                         ((state_q == S_IDLE) || (state_q == S_READY) || (state_q == S_DONE));

   assign accept_block = (state_q == S_READY) && i_valid && !i_start;

   // Block multiply or length multiply begins next cycle.
   assign enter_mult = accept_block || (state_q == S_LEN);

   always_comb
   begin
      state_next = state_q;
      case (state_q)
         S_IDLE:
         begin
            if (i_start)
            begin
               state_next = S_READY;
            end
         end
         S_READY:
         begin
            if (i_start)
            begin
               state_next = S_READY;
            end
            else if (i_valid)
            begin
               state_next = S_MULT;
            end
            else if (i_finish)
            begin
               state_next = S_LEN;
            end
         end
         S_MULT:
         begin
            if (write_q)
            begin
               state_next = S_READY;
            end
         end
         S_LEN:
         begin
            state_next = S_LEN_MULT;
         end
         S_LEN_MULT:
         begin
            if (write_q)
            begin
               state_next = S_DONE;
            end
         end
         S_DONE:
         begin
            state_next = i_start ? S_READY : S_IDLE;
         end
         default:
         begin
            state_next = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         state_q <= S_IDLE;
         load_q  <= 1'b0;
         write_q <= 1'b0;
      end
      else
      begin
         state_q <= state_next;
         load_q  <= enter_mult;
         // Write-back one cycle after the final step.
         write_q <= mult.last;
      end
   end

   assign mult.load     = load_q;
   assign o_write       = write_q;
   assign o_clear       = accept_start;
   assign o_count_block = accept_block;
   assign o_use_len     = (state_q == S_LEN) || (state_q == S_LEN_MULT);
   assign o_ready       = (state_q == S_READY);
   assign o_valid       = (state_q == S_DONE);

endmodule

// File: ghash_top.sv
module ghash_top
#(
   parameter int NB_DIGIT = ghash_pkg::NB_DIGIT_DEFAULT
)
(
   input  logic                          i_clock,
   input  logic                          i_reset,
   input  logic                          i_start,
   input  logic [ghash_pkg::NB_DATA-1:0] i_h_key,
   input  logic                          i_valid,
   input  logic                          i_is_aad,
   input  logic [ghash_pkg::NB_DATA-1:0] i_data_x,
   input  logic                          i_finish,
   output logic                          o_ready,
   output logic                          o_valid,
   output logic [ghash_pkg::NB_DATA-1:0] o_data_y
);

   logic clear;
   logic write;
   logic count_block;
   logic use_len;

   mult_if u_mult_if ();

   ghash_fsm u_fsm
   (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_start       (i_start),
      .i_valid       (i_valid),
      .i_finish      (i_finish),
      .mult          (u_mult_if.ctrl),
      .o_clear       (clear),
      .o_write       (write),
      .o_count_block (count_block),
      .o_use_len     (use_len),
      .o_ready       (o_ready),
      .o_valid       (o_valid)
   );

   ghash_step_counter #(.NB_DIGIT(NB_DIGIT)) u_step_counter
   (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .mult    (u_mult_if.timer)
   );

   gf_multiplier_gcm_spec #(.NB_DIGIT(NB_DIGIT)) u_multiplier
   (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .mult    (u_mult_if.datapath)
   );

   // Block and its type are taken on the valid cycle itself.
   ghash_accumulator u_accumulator
   (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .mult          (u_mult_if.source),
      .i_clear       (clear),
      .i_write       (write),
      .i_count_block (count_block),
      .i_is_aad      (i_is_aad),
      .i_use_len     (use_len),
      .i_h_key       (i_h_key),
      .i_data_x      (i_data_x),
      .o_data_y      (o_data_y)
   );

endmodule

// File: tb_ghash_tasks.svh
localparam int           NB_DIGIT      = 4;
localparam int           N_STEPS       = 128 / NB_DIGIT;
localparam int           RESET_CYCLES  = 8;
localparam int           N_RANDOM_MSGS = 6;
localparam int           TOTAL_BLOCKS  = 2 + 1 + N_RANDOM_MSGS * 7 + 2 + 6;
localparam logic [31:0]  LFSR_SEED     = 32'hc4434cf2;
localparam logic [127:0] REDUCE_WORD   = {8'he1, 120'd0};

// GCM test case 2, one text block and no AAD.
localparam logic [127:0] KNOWN_H = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
localparam logic [127:0] KNOWN_C = 128'h0388dace60b6a392f328c2b971b2fe78;
localparam logic [127:0] KNOWN_Y = 128'hf38cbb1ad69223dcc3457ae5b6b0f885;

// Outputs are read and inputs driven just after the rising edge.
task automatic tick();
   @(posedge clock);
   #1;
endtask

task automatic check_hex(input string name, input logic [127:0] got, input logic [127:0] exp);
   checks++;
   assert (got === exp) else
   begin
      $display("FAIL %s got %0h expected %0h", name, got, exp);
      errors++;
   end
endtask

task automatic wait_ready();
   int n;
   n = 0;
   while (!ready && n < 200)
   begin
      tick();
      n++;
   end
   assert (ready) else
   begin
      $display("o_ready did not come back within %0d cycles", n);
      errors++;
   end
endtask

task automatic start_msg(input logic [127:0] h);
   start = 1'b1;
   h_key = h;
   msg_count = 0;
   tick();
   start = 1'b0;
endtask

task automatic send_block(input logic aad, input logic [127:0] x);
   wait_ready();
   valid = 1'b1;
   is_aad = aad;
   data_x = x;
   msg_block[msg_count] = x;
   msg_aad[msg_count] = aad;
   msg_count++;
   tick();
   valid = 1'b0;
endtask

task automatic finish_msg(output logic [127:0] y);
   int n;
   wait_ready();
   finish = 1'b1;
   tick();
   finish = 1'b0;
   n = 0;
   while (!out_valid && n < 200)
   begin
      tick();
      n++;
   end
   assert (out_valid) else
   begin
      $display("o_valid never rose after the finish pulse");
      errors++;
   end
   y = data_y;
endtask

task automatic report_test(input string name, input int errors_before);
   tests++;
   if (errors == errors_before)
      $display("test %s ok", name);
   else
      $display("test %s had %0d errors", name, errors - errors_before);
endtask

task automatic test_known_vector();
   int           e0;
   logic [127:0] y;
   e0 = errors;
   start_msg(KNOWN_H);
   send_block(1'b0, KNOWN_C);
   finish_msg(y);
   check_hex("o_data_y", y, KNOWN_Y);
   check_hex("model ghash", model_ghash(KNOWN_H), KNOWN_Y);
   report_test("known vector", e0);
endtask

// Length block is zero, so Y stays zero.
task automatic test_empty_message();
   int           e0;
   logic [127:0] h;
   logic [127:0] y;
   e0 = errors;
   take_bits(128, h);
   start_msg(h);
   finish_msg(y);
   check_hex("o_data_y", y, '0);
   report_test("empty message", e0);
endtask

task automatic test_random_messages();
   int           e0;
   int           n_aad;
   int           n_text;
   logic [127:0] h;
   logic [127:0] x;
   logic [127:0] r;
   logic [127:0] y;
   e0 = errors;
   for (int m = 0; m < N_RANDOM_MSGS; m++)
   begin
      take_bits(128, h);
      take_bits(2, r);
      n_aad = (m == 0) ? 0 : int'(r[1:0]);
      take_bits(2, r);
      n_text = (m == 0) ? 0 : int'(r[1:0]);
      start_msg(h);
      for (int i = 0; i < n_aad + n_text; i++)
      begin
         take_bits(128, x);
         send_block(i < n_aad, x);
      end
      finish_msg(y);
      check_hex("o_data_y", y, model_ghash(h));
   end
   report_test("random messages", e0);
endtask

// Cycle counts are fixed by the block and finish timing.
task automatic test_latency();
   int           e0;
   int           n;
   logic [127:0] h;
   logic [127:0] x;
   e0 = errors;
   take_bits(128, h);
   take_bits(128, x);
   start_msg(h);
   send_block(1'b1, x);
   n = 0;
   while (!ready && n < 100)
   begin
      tick();
      n++;
   end
   check_hex("o_ready cycles", n, N_STEPS + 2);
   finish = 1'b1;
   tick();
   finish = 1'b0;
   n = 0;
   while (!out_valid && n < 100)
   begin
      tick();
      n++;
   end
   check_hex("o_valid cycles", n, N_STEPS + 3);
   check_hex("o_data_y", data_y, model_ghash(h));
   tick();
   check_hex("o_valid", out_valid, 1'b0);
   report_test("latency", e0);
endtask

task automatic test_reset_restart();
   int           e0;
   logic [127:0] h;
   logic [127:0] x;
   logic [127:0] junk;
   logic [127:0] y1;
   logic [127:0] y2;
   e0 = errors;
   take_bits(128, h);
   take_bits(128, x);
   take_bits(128, junk);
   // Reset taken in S_READY drops o_ready.
   start_msg(h);
   reset = 1'b1;
   repeat (RESET_CYCLES) tick();
   reset = 1'b0;
   check_hex("o_ready", ready, 1'b0);
   // Reset during the length multiply cancels the o_valid pulse.
   start_msg(h);
   finish = 1'b1;
   tick();
   finish = 1'b0;
   reset = 1'b1;
   repeat (RESET_CYCLES) tick();
   reset = 1'b0;
   for (int i = 0; i < N_STEPS + 3; i++)
   begin
      check_hex("o_valid", out_valid, 1'b0);
      tick();
   end
   start_msg(h);
   send_block(1'b1, x);
   finish_msg(y1);
   check_hex("o_data_y", y1, model_ghash(h));
   // Abandoned block must leave no trace in Y or the counts.
   start_msg(h);
   send_block(1'b0, junk);
   wait_ready();
   start_msg(h);
   send_block(1'b1, x);
   finish_msg(y2);
   check_hex("o_data_y", y2, y1);
   report_test("reset and restart", e0);
endtask

// File: tb_ghash_top.sv
module tb_ghash_top;

   logic         clock;
   logic         reset;
   logic         start;
   logic [127:0] h_key;
   logic         valid;
   logic         is_aad;
   logic [127:0] data_x;
   logic         finish;
   logic         ready;
   logic         out_valid;
   logic [127:0] data_y;

   int           errors;
   int           checks;
   int           tests;
   logic [31:0]  lfsr_state;

   // Blocks of the current message in arrival order, for the model.
   logic [127:0] msg_block [0:15];
   logic         msg_aad   [0:15];
   int           msg_count;

   `include "tb_ghash_tasks.svh"

   ghash_top #(.NB_DIGIT(NB_DIGIT)) UUT
   (
      .i_clock  (clock),
      .i_reset  (reset),
      .i_start  (start),
      .i_h_key  (h_key),
      .i_valid  (valid),
      .i_is_aad (is_aad),
      .i_data_x (data_x),
      .i_finish (finish),
      .o_ready  (ready),
      .o_valid  (out_valid),
      .o_data_y (data_y)
   );

   always #5 clock = ~clock;

   // Bit-serial multiply as written in the GCM specification.
   function automatic logic [127:0] gf_mult_spec(input logic [127:0] x, input logic [127:0] y);
      logic [127:0] z;
      logic [127:0] v;
      z = '0;
      v = y;
      for (int i = 0; i < 128; i++)
      begin
         if (x[127 - i])
            z = z ^ v;
         v = v[0] ? ((v >> 1) ^ REDUCE_WORD) : (v >> 1);
      end
      return z;
   endfunction

   // GHASH of the recorded message with the length block appended.
   function automatic logic [127:0] model_ghash(input logic [127:0] h);
      logic [127:0] y;
      logic [63:0]  aad_bits;
      logic [63:0]  text_bits;
      y = '0;
      aad_bits = '0;
      text_bits = '0;
      for (int i = 0; i < msg_count; i++)
      begin
         y = gf_mult_spec(y ^ msg_block[i], h);
         if (msg_aad[i])
            aad_bits = aad_bits + 64'd128;
         else
            text_bits = text_bits + 64'd128;
      end
      return gf_mult_spec(y ^ {aad_bits, text_bits}, h);
   endfunction

   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int nbits, output logic [127:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[126:0], lfsr_state[0]};
      end
   endtask

   initial
   begin
      clock = 1'b0;
      reset = 1'b1;
      start = 1'b0;
      h_key = '0;
      valid = 1'b0;
      is_aad = 1'b0;
      data_x = '0;
      finish = 1'b0;
      errors = 0;
      checks = 0;
      tests = 0;
      msg_count = 0;
      lfsr_state = LFSR_SEED;
      repeat (RESET_CYCLES) tick();
      reset = 1'b0;
      test_known_vector();
      test_empty_message();
      test_random_messages();
      test_latency();
      test_reset_restart();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // About 40 cycles per hashed block, plus slack for resets.
   initial
   begin
      repeat (RESET_CYCLES + TOTAL_BLOCKS * 40 + 200) @(posedge clock);
      $display("Watchdog timeout, the tests did not complete in time");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: project.f
+incdir+.
ghash_pkg.sv
ghash_ctrl_pkg.sv
mult_if.sv
gf_multiplier_gcm_spec.sv
ghash_step_counter.sv
ghash_accumulator.sv
ghash_fsm.sv
ghash_top.sv
tb_ghash_top.sv
